//--- src/alu_arith.sv
// Adder and subtractor unit
`timescale 1ns/1ps

module alu_arith (
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::alu_width_t w,
    input  alu_pkg::data_t      op0,
    input  alu_pkg::data_t      op1,
    input  logic                carry,
    alu_unit_if.unit            u
);

    alu_pkg::data_t a, b, bx, r;
    logic           sub, cin, cx, hc, c_w;
    logic [2:0]     cc;          // byte, word and long carry out
    logic [32:0]    ext_r;       // sign extended sum for V

    function automatic logic [32:0] extend(alu_pkg::alu_width_t wd, alu_pkg::data_t x);
        case (wd)
            alu_pkg::W_BYTE: extend = {{25{x[7]}}, x[7:0]};
            alu_pkg::W_WORD: extend = {{17{x[15]}}, x[15:0]};
            default:         extend = {x[31], x};
        endcase
    endfunction

    always_comb begin
        sub = op inside {alu_pkg::ALU_SUB, alu_pkg::ALU_SBC, alu_pkg::ALU_CP, alu_pkg::ALU_NEG};
        a   = (op == alu_pkg::ALU_NEG) ? '0 : op0;   // NEG is 0 - op0
        b   = (op == alu_pkg::ALU_NEG) ? op0 : op1;
        cin = (op inside {alu_pkg::ALU_ADC, alu_pkg::ALU_SBC}) && carry;
        // a - b - cin done as a + ~b + ~cin
        bx  = sub ? ~b : b;
        cx  = sub ? ~cin : cin;

        {hc, r[alu_pkg::HALF_BITS-1:0]} = {1'b0, a[alu_pkg::HALF_BITS-1:0]}
                                        + {1'b0, bx[alu_pkg::HALF_BITS-1:0]}
                                        + {4'd0, cx};
        {cc[0], r[7:alu_pkg::HALF_BITS]} = {1'b0, a[7:alu_pkg::HALF_BITS]}
                                         + {1'b0, bx[7:alu_pkg::HALF_BITS]}
                                         + {4'd0, hc};
        {cc[1], r[15:8]}  = {1'b0, a[15:8]} + {1'b0, bx[15:8]} + {8'd0, cc[0]};
        {cc[2], r[31:16]} = {1'b0, a[31:16]} + {1'b0, bx[31:16]} + {16'd0, cc[1]};

        if (sub) begin
            ext_r = extend(w, a) - extend(w, b) - {32'd0, cin};
        end else begin
            ext_r = extend(w, a) + extend(w, b) + {32'd0, cin};
        end

        case (w)
            alu_pkg::W_BYTE: c_w = cc[0];
            alu_pkg::W_WORD: c_w = cc[1];
            default:         c_w = cc[2];
        endcase
    end

    assign u.own = (w != alu_pkg::W_NONE) &&
                   (op inside {alu_pkg::ALU_ADD, alu_pkg::ALU_ADC, alu_pkg::ALU_SUB,
                               alu_pkg::ALU_SBC, alu_pkg::ALU_CP, alu_pkg::ALU_NEG});
    assign u.done       = u.own;
    assign u.write_rslt = (op != alu_pkg::ALU_CP);   // compare only sets flags
    assign u.rslt       = r;
    assign u.nx_flags   = {alu_pkg::sign_of(w, r),
                           alu_pkg::zero_of(w, r),
                           hc ^ sub,                   // borrow on subtract
                           ext_r[32] ^ alu_pkg::sign_of(w, r),
                           sub,
                           c_w ^ sub};

endmodule

//--- src/alu_bitops.sv
// Logic, bit and carry flag unit
`timescale 1ns/1ps

module alu_bitops (
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::alu_width_t w,
    input  alu_pkg::data_t      op0,
    input  alu_pkg::data_t      op1,
    input  alu_pkg::flags_t     flags_cur,
    alu_unit_if.unit            u
);

    alu_pkg::bit_idx_t idx;
    alu_pkg::data_t    r;
    logic              s, z, h, v, n, c, wr;

    always_comb begin
        idx = op1[3:0];                    // bit number from source
        r   = op0;
        wr  = 1'b0;
        s   = flags_cur[alu_pkg::FLAG_S_POS];
        z   = flags_cur[alu_pkg::FLAG_Z_POS];
        h   = flags_cur[alu_pkg::FLAG_H_POS];
        v   = flags_cur[alu_pkg::FLAG_V_POS];
        n   = flags_cur[alu_pkg::FLAG_N_POS];
        c   = flags_cur[alu_pkg::FLAG_C_POS];
        case (op)
            alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR: begin
                if (op == alu_pkg::ALU_AND) begin
                    r = op0 & op1;
                end else if (op == alu_pkg::ALU_OR) begin
                    r = op0 | op1;
                end else begin
                    r = op0 ^ op1;
                end
                wr = 1'b1;
                s  = alu_pkg::sign_of(w, r);
                z  = alu_pkg::zero_of(w, r);
                h  = (op == alu_pkg::ALU_AND);
                v  = alu_pkg::even_of(w, r);
                n  = 1'b0;
                c  = 1'b0;
            end
            alu_pkg::ALU_BIT, alu_pkg::ALU_TSET: begin
                z = ~op0[idx];
                h = 1'b1;
                n = 1'b0;
                if (op == alu_pkg::ALU_TSET) begin
                    r[idx] = 1'b1;
                    wr     = 1'b1;
                end
            end
            alu_pkg::ALU_SET: begin
                r[idx] = 1'b1;
                wr     = 1'b1;
            end
            alu_pkg::ALU_RES: begin
                r[idx] = 1'b0;
                wr     = 1'b1;
            end
            alu_pkg::ALU_CHG: begin
                r[idx] = ~op0[idx];
                wr     = 1'b1;
            end
            alu_pkg::ALU_SCF: begin
                c = 1'b1;
                h = 1'b0;
                n = 1'b0;
            end
            alu_pkg::ALU_RCF: begin
                c = 1'b0;
                h = 1'b0;
                n = 1'b0;
            end
            alu_pkg::ALU_CCF: begin
                c = ~flags_cur[alu_pkg::FLAG_C_POS];
                n = 1'b0;
            end
            alu_pkg::ALU_ZCF: begin
                c = ~flags_cur[alu_pkg::FLAG_Z_POS];  // C gets inverted Z
                n = 1'b0;
            end
            default: ;
        endcase
    end

    assign u.own = (w != alu_pkg::W_NONE) &&
                   (op inside {alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR,
                               alu_pkg::ALU_BIT, alu_pkg::ALU_SET, alu_pkg::ALU_RES,
                               alu_pkg::ALU_CHG, alu_pkg::ALU_TSET, alu_pkg::ALU_SCF,
                               alu_pkg::ALU_RCF, alu_pkg::ALU_CCF, alu_pkg::ALU_ZCF});
    assign u.done       = u.own;
    assign u.write_rslt = wr;
    assign u.rslt       = r;
    assign u.nx_flags   = {s, z, h, v, n, c};

endmodule

//--- src/alu_flag_reg.sv
// Result and flag register
`timescale 1ns/1ps

module alu_flag_reg (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    alu_unit_if.sink        arith,
    alu_unit_if.sink        bitops,
    alu_unit_if.sink        shift,
    output alu_pkg::data_t  dout,
    output alu_pkg::flags_t flags,
    output logic            carry
);

    logic           ld, ld_rslt;
    alu_pkg::data_t nx_rslt;
    logic [5:0]     nx_flags;    // S Z H V N C

    always_comb begin
        ld       = 1'b0;
        ld_rslt  = 1'b0;
        nx_rslt  = shift.rslt;
        nx_flags = shift.nx_flags;
        if (shift.own) begin                      // running shift blocks the others
            ld      = shift.done;
            ld_rslt = shift.done && shift.write_rslt;
        end else if (arith.own && arith.done) begin
            ld       = 1'b1;
            ld_rslt  = arith.write_rslt;
            nx_rslt  = arith.rslt;
            nx_flags = arith.nx_flags;
        end else if (bitops.own && bitops.done) begin
            ld       = 1'b1;
            ld_rslt  = bitops.write_rslt;
            nx_rslt  = bitops.rslt;
            nx_flags = bitops.nx_flags;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout  <= '0;
            flags <= '0;
        end else if (cen && ld) begin
            if (ld_rslt) begin
                dout <= nx_rslt;
            end
            flags[alu_pkg::FLAG_S_POS] <= nx_flags[5];
            flags[alu_pkg::FLAG_Z_POS] <= nx_flags[4];
            flags[alu_pkg::FLAG_H_POS] <= nx_flags[3];
            flags[alu_pkg::FLAG_V_POS] <= nx_flags[2];
            flags[alu_pkg::FLAG_N_POS] <= nx_flags[1];
            flags[alu_pkg::FLAG_C_POS] <= nx_flags[0];
        end
    end

    assign carry = flags[alu_pkg::FLAG_C_POS];

    // unit decoders must not overlap, and nothing issues over a running shift
    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        cen |-> $onehot0({arith.own, bitops.own, shift.own}))
        else $error("more than one ALU unit owns the op");

endmodule

//--- src/alu_pkg.sv
// ALU shared types and helpers
package alu_pkg;

    typedef logic [31:0] data_t;       // operand and result
    typedef logic [7:0]  flags_t;      // S Z 0 H 0 V N C
    typedef logic [3:0]  bit_idx_t;    // bit number for bit ops
    typedef logic [4:0]  shift_cnt_t;  // 1..16 shift steps

    localparam int HALF_BITS  = 4;     // nibble for half carry
    localparam int FLAG_S_POS = 7;
    localparam int FLAG_Z_POS = 6;
    localparam int FLAG_H_POS = 4;
    localparam int FLAG_V_POS = 2;
    localparam int FLAG_N_POS = 1;
    localparam int FLAG_C_POS = 0;

    // one-hot operand width, W_NONE means idle
    typedef enum logic [2:0] {
        W_NONE = 3'b000,
        W_BYTE = 3'b001,
        W_WORD = 3'b010,
        W_LONG = 3'b100
    } alu_width_t;

    typedef enum logic [5:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP,  ALU_NEG,
        ALU_AND, ALU_OR,  ALU_XOR,
        ALU_BIT, ALU_SET, ALU_RES, ALU_CHG, ALU_TSET,
        ALU_SCF, ALU_RCF, ALU_CCF, ALU_ZCF,
        ALU_RLC, ALU_RRC, ALU_RL,  ALU_RR,
        ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL
    } alu_op_t;

    function automatic logic sign_of(alu_width_t wd, data_t x);
        sign_of = (wd == W_BYTE) ? x[7] : (wd == W_WORD) ? x[15] : x[31];
    endfunction

    function automatic logic zero_of(alu_width_t wd, data_t x);
        zero_of = (wd == W_BYTE) ? (x[7:0] == '0) :
                  (wd == W_WORD) ? (x[15:0] == '0) : (x == '0);
    endfunction

    // even parity, only byte or word wide
    function automatic logic even_of(alu_width_t wd, data_t x);
        even_of = (wd == W_BYTE) ? ~^x[7:0] : ~^x[15:0];
    endfunction

endpackage

//--- src/alu_shifter.sv
// Multi-cycle shift and rotate unit
`timescale 1ns/1ps

module alu_shifter (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::alu_width_t w,
    input  alu_pkg::data_t      op0,
    input  alu_pkg::data_t      op1,
    input  logic                carry,
    output logic                busy,
    alu_unit_if.unit            u
);

    alu_pkg::data_t      val_q;      // partly shifted operand
    alu_pkg::alu_op_t    op_q;
    alu_pkg::alu_width_t w_q;
    logic                c_q;        // last bit shifted out
    alu_pkg::shift_cnt_t cnt_q;      // steps still to run

    alu_pkg::data_t      src, r;
    alu_pkg::alu_op_t    op_s;
    alu_pkg::alu_width_t w_s;
    alu_pkg::shift_cnt_t cnt_s;
    logic                issue, own, done, cin, msb, fill, cout;

    always_comb begin
        issue = (w != alu_pkg::W_NONE) &&
                (op inside {alu_pkg::ALU_RLC, alu_pkg::ALU_RRC, alu_pkg::ALU_RL,
                            alu_pkg::ALU_RR, alu_pkg::ALU_SLA, alu_pkg::ALU_SRA,
                            alu_pkg::ALU_SLL, alu_pkg::ALU_SRL});
        src   = busy ? val_q : op0;
        op_s  = busy ? op_q : op;
        w_s   = busy ? w_q : w;
        cin   = busy ? c_q : carry;
        cnt_s = busy ? cnt_q : {op1[3:0] == 4'd0, op1[3:0]};   // 0 means 16
        msb   = alu_pkg::sign_of(w_s, src);
        r     = src;                                           // bits above width kept
        if (op_s inside {alu_pkg::ALU_RLC, alu_pkg::ALU_RL, alu_pkg::ALU_SLA,
                         alu_pkg::ALU_SLL}) begin
            fill = (op_s == alu_pkg::ALU_RLC) ? msb : (op_s == alu_pkg::ALU_RL) && cin;
            cout = msb;
            case (w_s)
                alu_pkg::W_BYTE: r[7:0]  = {src[6:0], fill};
                alu_pkg::W_WORD: r[15:0] = {src[14:0], fill};
                default:         r       = {src[30:0], fill};
            endcase
        end else begin
            fill = (op_s == alu_pkg::ALU_RRC) ? src[0] :
                   (op_s == alu_pkg::ALU_RR)  ? cin :
                   (op_s == alu_pkg::ALU_SRA) ? msb : 1'b0;
            cout = src[0];
            case (w_s)
                alu_pkg::W_BYTE: r[7:0]  = {fill, src[7:1]};
                alu_pkg::W_WORD: r[15:0] = {fill, src[15:1]};
                default:         r       = {fill, src[31:1]};
            endcase
        end
        own  = busy || issue;
        done = own && (cnt_s == 5'd1);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            cnt_q <= '0;
        end else if (cen) begin
            if (own && !done) begin
                busy  <= 1'b1;
                cnt_q <= cnt_s - 5'd1;
            end else if (done) begin
                busy  <= 1'b0;          // final step
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && own && !done) begin
            val_q <= r;
            c_q   <= cout;
            op_q  <= op_s;
            w_q   <= w_s;
        end
    end

    assign u.own        = own;
    assign u.done       = done;
    assign u.write_rslt = 1'b1;
    assign u.rslt       = r;
    assign u.nx_flags   = {alu_pkg::sign_of(w_s, r), alu_pkg::zero_of(w_s, r), 1'b0,
                           alu_pkg::even_of(w_s, r), 1'b0, cout};

    // the issuer waits for busy to drop
    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
        busy && cen |-> w == alu_pkg::W_NONE)
        else $error("op issued while shifter busy");

endmodule

//--- src/alu_top.sv
// Integer ALU top level
`timescale 1ns/1ps

module alu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::alu_width_t w,
    input  alu_pkg::data_t      op0,
    input  alu_pkg::data_t      op1,
    output alu_pkg::data_t      dout,
    output alu_pkg::flags_t     flags,
    output logic                busy
);

    logic carry;    // stored C flag

    alu_unit_if arith_if ();
    alu_unit_if bitops_if ();
    alu_unit_if shift_if ();

    alu_arith u_arith (
        .op    (op),
        .w     (w),
        .op0   (op0),
        .op1   (op1),
        .carry (carry),
        .u     (arith_if)
    );

    alu_bitops u_bitops (
        .op        (op),
        .w         (w),
        .op0       (op0),
        .op1       (op1),
        .flags_cur (flags),
        .u         (bitops_if)
    );

    alu_shifter u_shifter (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .op    (op),
        .w     (w),
        .op0   (op0),
        .op1   (op1),
        .carry (carry),
        .busy  (busy),
        .u     (shift_if)
    );

    alu_flag_reg u_flag_reg (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .arith  (arith_if),
        .bitops (bitops_if),
        .shift  (shift_if),
        .dout   (dout),
        .flags  (flags),
        .carry  (carry)
    );

endmodule

//--- src/alu_unit_if.sv
// Execution unit result channel
`timescale 1ns/1ps

interface alu_unit_if;

    logic           own;         // unit runs the current op
    alu_pkg::data_t rslt;
    logic [5:0]     nx_flags;    // S Z H V N C
    logic           write_rslt;  // load dout too
    logic           done;        // last cycle of the op

    modport unit (
        output own,
        output rslt,
        output nx_flags,
        output write_rslt,
        output done
    );

    modport sink (
        input own,
        input rslt,
        input nx_flags,
        input write_rslt,
        input done
    );

endinterface

//--- tb.f
+incdir+verification
src/alu_pkg.sv
src/alu_unit_if.sv
src/alu_arith.sv
src/alu_bitops.sv
src/alu_shifter.sv
src/alu_flag_reg.sv
src/alu_top.sv
verification/alu_tb.sv

//--- verification/alu_tb_table.svh
// ALU test stimulus table
`ifndef ALU_TB_TABLE_SVH
`define ALU_TB_TABLE_SVH

// columns are name, setup op for the flags, op under test, width in bits, op0, op1
// the setup op runs on the same operands
// shift rows take the count from op1[3:0] where 0 means 16
task automatic load_table();
    // arithmetic group
    add_row("add_b_ovf", alu_pkg::ALU_RCF, alu_pkg::ALU_ADD, 8, 'h7f, 'h01);
    add_row("add_b_cy", alu_pkg::ALU_RCF, alu_pkg::ALU_ADD, 8, 'hff, 'h01);
    add_row("adc_b", alu_pkg::ALU_SCF, alu_pkg::ALU_ADC, 8, 'h0f, 'h10);
    add_row("sub_b", alu_pkg::ALU_RCF, alu_pkg::ALU_SUB, 8, 'h10, 'h01);
    add_row("sbc_b", alu_pkg::ALU_SCF, alu_pkg::ALU_SBC, 8, 'h00, 'h00);
    add_row("cp_b", alu_pkg::ALU_RCF, alu_pkg::ALU_CP, 8, 'h40, 'h40);
    add_row("neg_b", alu_pkg::ALU_RCF, alu_pkg::ALU_NEG, 8, 'h80, 'h00);
    add_row("add_w", alu_pkg::ALU_RCF, alu_pkg::ALU_ADD, 16, 'h7fff, 'h0001);
    add_row("adc_w", alu_pkg::ALU_SCF, alu_pkg::ALU_ADC, 16, 'hffff, 'h0000);
    add_row("sub_w", alu_pkg::ALU_RCF, alu_pkg::ALU_SUB, 16, 'h8000, 'h0001);
    add_row("sbc_w", alu_pkg::ALU_SCF, alu_pkg::ALU_SBC, 16, 'h1234, 'h1234);
    add_row("cp_w", alu_pkg::ALU_RCF, alu_pkg::ALU_CP, 16, 'h0100, 'h0200);
    add_row("neg_w", alu_pkg::ALU_RCF, alu_pkg::ALU_NEG, 16, 'h0001, 'h0000);
    add_row("add_l", alu_pkg::ALU_RCF, alu_pkg::ALU_ADD, 32, 'h7fffffff, 'h1);
    add_row("adc_l", alu_pkg::ALU_SCF, alu_pkg::ALU_ADC, 32, 'hffffffff, 'h0);
    add_row("sub_l", alu_pkg::ALU_RCF, alu_pkg::ALU_SUB, 32, 'h0, 'h1);
    add_row("sbc_l", alu_pkg::ALU_SCF, alu_pkg::ALU_SBC, 32, 'h80000000, 'h0);
    add_row("cp_l", alu_pkg::ALU_RCF, alu_pkg::ALU_CP, 32, 'h12345678, 'h12345679);
    add_row("neg_l", alu_pkg::ALU_RCF, alu_pkg::ALU_NEG, 32, 'h80000000, 'h0);
    // logic group
    add_row("and_b", alu_pkg::ALU_RCF, alu_pkg::ALU_AND, 8, 'hf0, 'h3c);
    add_row("or_w", alu_pkg::ALU_CP, alu_pkg::ALU_OR, 16, 'h0f00, 'h00f0);
    add_row("xor_l", alu_pkg::ALU_SCF, alu_pkg::ALU_XOR, 32, 'hffff0000, 'hffff0001);
    // bit group with op1 as the bit number
    add_row("bit_clr", alu_pkg::ALU_RCF, alu_pkg::ALU_BIT, 16, 'h0000, 'h3);
    add_row("bit_set", alu_pkg::ALU_CP, alu_pkg::ALU_BIT, 16, 'h8000, 'hf);
    add_row("set_w", alu_pkg::ALU_RCF, alu_pkg::ALU_SET, 16, 'h0000, 'h5);
    add_row("res_l", alu_pkg::ALU_SCF, alu_pkg::ALU_RES, 32, 'hffffffff, 'h9);
    add_row("chg_b", alu_pkg::ALU_RCF, alu_pkg::ALU_CHG, 8, 'h55, 'h0);
    add_row("tset_w", alu_pkg::ALU_SCF, alu_pkg::ALU_TSET, 16, 'h0000, 'hc);
    // carry flag group
    add_row("scf", alu_pkg::ALU_SUB, alu_pkg::ALU_SCF, 8, 'h0, 'h0);
    add_row("rcf", alu_pkg::ALU_SCF, alu_pkg::ALU_RCF, 8, 'h0, 'h0);
    add_row("ccf", alu_pkg::ALU_SUB, alu_pkg::ALU_CCF, 8, 'h0, 'h0);
    add_row("zcf_z", alu_pkg::ALU_XOR, alu_pkg::ALU_ZCF, 8, 'h5, 'h5);
    add_row("zcf_nz", alu_pkg::ALU_OR, alu_pkg::ALU_ZCF, 8, 'h1, 'h0);
    // shift and rotate group
    add_row("rlc_b1", alu_pkg::ALU_RCF, alu_pkg::ALU_RLC, 8, 'h81, 'h1);
    add_row("rrc_w5", alu_pkg::ALU_RCF, alu_pkg::ALU_RRC, 16, 'h1235, 'h5);
    add_row("rl_b5", alu_pkg::ALU_SCF, alu_pkg::ALU_RL, 8, 'h96, 'h5);
    add_row("rr_l0", alu_pkg::ALU_SCF, alu_pkg::ALU_RR, 32, 'h8001, 'h0);
    add_row("sla_w1", alu_pkg::ALU_RCF, alu_pkg::ALU_SLA, 16, 'hc000, 'h1);
    add_row("sra_b5", alu_pkg::ALU_SUB, alu_pkg::ALU_SRA, 8, 'h90, 'h5);
    add_row("sll_l5", alu_pkg::ALU_RCF, alu_pkg::ALU_SLL, 32, 'h80000001, 'h5);
    add_row("srl_w0", alu_pkg::ALU_RCF, alu_pkg::ALU_SRL, 16, 'hffff, 'h0);
    add_row("rlc_l0", alu_pkg::ALU_RCF, alu_pkg::ALU_RLC, 32, 'h80000001, 'h0);
    add_row("sra_w1", alu_pkg::ALU_SCF, alu_pkg::ALU_SRA, 16, 'h8001, 'h1);
    // random operands
    add_rand_row("rnd_add_l", alu_pkg::ALU_RCF, alu_pkg::ALU_ADD, 32);
    add_rand_row("rnd_adc_b", alu_pkg::ALU_SCF, alu_pkg::ALU_ADC, 8);
    add_rand_row("rnd_sub_b", alu_pkg::ALU_RCF, alu_pkg::ALU_SUB, 8);
    add_rand_row("rnd_sbc_w", alu_pkg::ALU_SCF, alu_pkg::ALU_SBC, 16);
    add_rand_row("rnd_cp_l", alu_pkg::ALU_RCF, alu_pkg::ALU_CP, 32);
    add_rand_row("rnd_and_w", alu_pkg::ALU_RCF, alu_pkg::ALU_AND, 16);
    add_rand_row("rnd_xor_b", alu_pkg::ALU_SCF, alu_pkg::ALU_XOR, 8);
endtask

`endif

//--- verification/alu_tb.sv
// ALU testbench
`timescale 1ns/1ps

module alu_tb;

    localparam int MAX_ROWS   = 64;
    localparam int WAIT_LIMIT = 40;    // cycles for busy to fall

    logic                clk;
    logic                rst;
    logic                cen;
    alu_pkg::alu_op_t    op;
    alu_pkg::alu_width_t w;
    alu_pkg::data_t      op0;
    alu_pkg::data_t      op1;
    alu_pkg::data_t      dout;
    alu_pkg::flags_t     flags;
    logic                busy;

    string               row_name  [MAX_ROWS];
    alu_pkg::alu_op_t    row_setup [MAX_ROWS];   // op that places the flags
    alu_pkg::alu_op_t    row_op    [MAX_ROWS];
    int                  row_bits  [MAX_ROWS];
    alu_pkg::data_t      row_a     [MAX_ROWS];
    alu_pkg::data_t      row_b     [MAX_ROWS];
    logic                row_rnd   [MAX_ROWS];   // draw operands at run time
    int                  n_rows;

    alu_pkg::data_t      exp_dout;               // reference model state
    alu_pkg::flags_t     exp_flags;
    int                  n_checks;
    int                  n_errors;

    alu_top dut (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .op    (op),
        .w     (w),
        .op0   (op0),
        .op1   (op1),
        .dout  (dout),
        .flags (flags),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_row(input string nm, input alu_pkg::alu_op_t su,
                           input alu_pkg::alu_op_t o, input int bits,
                           input alu_pkg::data_t a, input alu_pkg::data_t b);
        row_name[n_rows]  = nm;
        row_setup[n_rows] = su;
        row_op[n_rows]    = o;
        row_bits[n_rows]  = bits;
        row_a[n_rows]     = a;
        row_b[n_rows]     = b;
        row_rnd[n_rows]   = 1'b0;
        n_rows++;
    endtask

    task automatic add_rand_row(input string nm, input alu_pkg::alu_op_t su,
                                input alu_pkg::alu_op_t o, input int bits);
        add_row(nm, su, o, bits, '0, '0);
        row_rnd[n_rows-1] = 1'b1;
    endtask

    `include "alu_tb_table.svh"

    function automatic alu_pkg::alu_width_t width_of(input int bits);
        case (bits)
            8:       return alu_pkg::W_BYTE;
            16:      return alu_pkg::W_WORD;
            default: return alu_pkg::W_LONG;
        endcase
    endfunction

    function automatic alu_pkg::data_t width_mask(input int bits);
        return (bits == 32) ? 32'hffff_ffff : (32'd1 << bits) - 32'd1;
    endfunction

    // signed value of the low bits of x
    function automatic longint sext(input int bits, input alu_pkg::data_t x);
        longint t;
        t = {32'd0, x & width_mask(bits)};
        if (x[bits-1]) begin
            t = t - (longint'(1) << bits);
        end
        return t;
    endfunction

    function automatic logic even_par(input int bits, input alu_pkg::data_t x);
        return (bits == 8) ? ~^x[7:0] : ~^x[15:0];   // long width counts 16 bits
    endfunction

    function automatic logic is_shift(input alu_pkg::alu_op_t o);
        return (o == alu_pkg::ALU_RLC) || (o == alu_pkg::ALU_RRC) || (o == alu_pkg::ALU_RL) ||
               (o == alu_pkg::ALU_RR) || (o == alu_pkg::ALU_SLA) || (o == alu_pkg::ALU_SRA) ||
               (o == alu_pkg::ALU_SLL) || (o == alu_pkg::ALU_SRL);
    endfunction

    function automatic alu_pkg::flags_t pack_flags(input logic s, input logic z, input logic h,
                                                   input logic v, input logic n, input logic c);
        alu_pkg::flags_t f;
        f = '0;
        f[alu_pkg::FLAG_S_POS] = s;
        f[alu_pkg::FLAG_Z_POS] = z;
        f[alu_pkg::FLAG_H_POS] = h;
        f[alu_pkg::FLAG_V_POS] = v;
        f[alu_pkg::FLAG_N_POS] = n;
        f[alu_pkg::FLAG_C_POS] = c;
        return f;
    endfunction

    task automatic model_op(input alu_pkg::alu_op_t o, input int bits,
                            input alu_pkg::data_t a, input alu_pkg::data_t b);
        alu_pkg::data_t m, x, y, r, bm;
        longint         sv, lim;
        int             cin, cnt, k;
        logic           sub, h, v, c, top, fill, left;
        m   = width_mask(bits);
        c   = exp_flags[alu_pkg::FLAG_C_POS];
        cin = 0;
        bm  = 32'd1 << b[3:0];
        r   = a;
        case (o)
            alu_pkg::ALU_ADD, alu_pkg::ALU_ADC, alu_pkg::ALU_SUB,
            alu_pkg::ALU_SBC, alu_pkg::ALU_CP, alu_pkg::ALU_NEG: begin
                sub = (o == alu_pkg::ALU_SUB) || (o == alu_pkg::ALU_SBC) ||
                      (o == alu_pkg::ALU_CP) || (o == alu_pkg::ALU_NEG);
                if ((o == alu_pkg::ALU_ADC) || (o == alu_pkg::ALU_SBC)) begin
                    cin = int'(c);
                end
                x = (o == alu_pkg::ALU_NEG) ? '0 : a;     // NEG is 0 - op0
                y = (o == alu_pkg::ALU_NEG) ? a : b;
                if (sub) begin
                    r  = x - y - cin;
                    h  = int'(x[3:0]) < int'(y[3:0]) + cin;    // half borrow
                    c  = {32'd0, x & m} < {32'd0, y & m} + cin;
                    sv = sext(bits, x) - sext(bits, y) - cin;
                end else begin
                    r  = x + y + cin;
                    h  = int'(x[3:0]) + int'(y[3:0]) + cin > 15;
                    c  = {32'd0, x & m} + {32'd0, y & m} + cin > {32'd0, m};
                    sv = sext(bits, x) + sext(bits, y) + cin;
                end
                lim = longint'(1) << (bits - 1);
                v   = (sv >= lim) || (sv < -lim);           // signed overflow
                if (o != alu_pkg::ALU_CP) begin
                    exp_dout = r;
                end
                exp_flags = pack_flags(r[bits-1], (r & m) == '0, h, v, sub, c);
            end
            alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR: begin
                r = (o == alu_pkg::ALU_AND) ? (a & b) : (o == alu_pkg::ALU_OR) ? (a | b) : (a ^ b);
                exp_dout  = r;
                exp_flags = pack_flags(r[bits-1], (r & m) == '0, o == alu_pkg::ALU_AND,
                                       even_par(bits, r), 1'b0, 1'b0);
            end
            alu_pkg::ALU_BIT, alu_pkg::ALU_TSET: begin
                exp_flags[alu_pkg::FLAG_Z_POS] = ~a[b[3:0]];
                exp_flags[alu_pkg::FLAG_H_POS] = 1'b1;
                exp_flags[alu_pkg::FLAG_N_POS] = 1'b0;
                if (o == alu_pkg::ALU_TSET) begin
                    exp_dout = a | bm;
                end
            end
            alu_pkg::ALU_SET: exp_dout = a | bm;
            alu_pkg::ALU_RES: exp_dout = a & ~bm;
            alu_pkg::ALU_CHG: exp_dout = a ^ bm;
            alu_pkg::ALU_SCF, alu_pkg::ALU_RCF: begin
                exp_flags[alu_pkg::FLAG_C_POS] = (o == alu_pkg::ALU_SCF);
                exp_flags[alu_pkg::FLAG_H_POS] = 1'b0;
                exp_flags[alu_pkg::FLAG_N_POS] = 1'b0;
            end
            alu_pkg::ALU_CCF, alu_pkg::ALU_ZCF: begin
                if (o == alu_pkg::ALU_CCF) begin
                    exp_flags[alu_pkg::FLAG_C_POS] = ~c;
                end else begin
                    exp_flags[alu_pkg::FLAG_C_POS] = ~exp_flags[alu_pkg::FLAG_Z_POS];
                end
                exp_flags[alu_pkg::FLAG_N_POS] = 1'b0;
            end
            default: begin                                  // shift group, one bit per step
                left = (o == alu_pkg::ALU_RLC) || (o == alu_pkg::ALU_RL) ||
                       (o == alu_pkg::ALU_SLA) || (o == alu_pkg::ALU_SLL);
                cnt  = (b[3:0] == 4'd0) ? 16 : int'(b[3:0]);
                for (k = 0; k < cnt; k++) begin
                    top = r[bits-1];
                    if (left) begin
                        fill = (o == alu_pkg::ALU_RLC) ? top : (o == alu_pkg::ALU_RL) ? c : 1'b0;
                        c    = top;
                        r    = (r & ~m) | (((r << 1) | {31'd0, fill}) & m);
                    end else begin
                        fill = (o == alu_pkg::ALU_RRC) ? r[0] : (o == alu_pkg::ALU_RR) ? c :
                               (o == alu_pkg::ALU_SRA) ? top : 1'b0;
                        c    = r[0];
                        r    = (r & ~m) | ((r & m) >> 1) | ({31'd0, fill} << (bits - 1));
                    end
                end
                exp_dout  = r;
                exp_flags = pack_flags(r[bits-1], (r & m) == '0, 1'b0, even_par(bits, r),
                                       1'b0, c);
            end
        endcase
    endtask

    task automatic check_val(input string nm, input string what,
                             input alu_pkg::data_t expv, input alu_pkg::data_t actv);
        n_checks++;
        if (actv !== expv) begin
            $display("ERROR %s %s expected %h actual %h", nm, what, expv, actv);
            n_errors++;
        end
    endtask

    // issue for one enabled cycle, then wait for busy to drop
    task automatic run_op(input string nm, input alu_pkg::alu_op_t o, input int bits,
                          input alu_pkg::data_t a, input alu_pkg::data_t b);
        int   waited;
        logic busy_seen;
        logic busy_exp;
        busy_exp = is_shift(o) && (b[3:0] != 4'd1);
        op  = o;
        w   = width_of(bits);
        op0 = a;
        op1 = b;
        @(negedge clk);
        w         = alu_pkg::W_NONE;
        busy_seen = busy;
        waited    = 0;
        while (busy && (waited < WAIT_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("%s: busy still high after %0d cycles", nm, WAIT_LIMIT);
            n_errors++;
        end else begin
            model_op(o, bits, a, b);
            check_val(nm, "dout", exp_dout, dout);
            check_val(nm, "flags", {24'd0, exp_flags}, {24'd0, flags});
            check_val(nm, "busy", {31'd0, busy_exp}, {31'd0, busy_seen});
        end
    endtask

    initial begin
        int i;
        rst       = 1'b1;
        cen       = 1'b0;
        op        = alu_pkg::ALU_ADD;
        w         = alu_pkg::W_NONE;
        op0       = '0;
        op1       = '0;
        exp_dout  = '0;
        exp_flags = '0;
        n_checks  = 0;
        n_errors  = 0;
        n_rows    = 0;
        void'($urandom(32'hc47e_a0a0));
        load_table();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_val("reset", "dout", '0, dout);
        check_val("reset", "flags", '0, {24'd0, flags});
        check_val("reset", "busy", '0, {31'd0, busy});
        cen = 1'b1;
        for (i = 0; i < n_rows; i++) begin
            if (row_rnd[i]) begin
                row_a[i] = $urandom();
                row_b[i] = $urandom();
            end
            run_op({row_name[i], "_setup"}, row_setup[i], row_bits[i], row_a[i], row_b[i]);
            run_op(row_name[i], row_op[i], row_bits[i], row_a[i], row_b[i]);
        end
        $display("alu_tb: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
